/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  localparam int ADDR_WIDTH     = 32;
  localparam int WORD_WIDTH     = 32;
  localparam int BE_WIDTH       = WORD_WIDTH / 8;
  localparam int LINE_WORDS     = 4;                   // also beats per burst
  localparam int LINE_WIDTH     = LINE_WORDS * WORD_WIDTH;
  localparam int NUM_SETS       = 64;
  localparam int NUM_WAYS       = 4;
  localparam int OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
  localparam int INDEX_WIDTH    = $clog2(NUM_SETS);
  localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS);

  localparam logic [10:0] LFSR_SEED = 11'd101;

  typedef logic [ADDR_WIDTH-1:0]       addr_t;
  typedef logic [WORD_WIDTH-1:0]       word_t;
  typedef logic [BE_WIDTH-1:0]         be_t;
  typedef logic [LINE_WIDTH-1:0]       line_t;  // word 0 in the low bits
  typedef logic [TAG_WIDTH-1:0]        tag_t;
  typedef logic [INDEX_WIDTH-1:0]      index_t;
  typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

/* rtl/cache_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_ram import cache_pkg::*; #(
  parameter type entry_t = tag_entry_t
) (
  input  logic   clock,
  input  logic   reset_n,
  input  index_t index,
  input  logic   wr_en,
  input  entry_t wr_entry,
  output entry_t entry
);

  entry_t mem [NUM_SETS];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_SETS; i++) begin
        mem[i] <= '0;  // all tags invalid
      end
    end else if (wr_en) begin
      mem[index] <= wr_entry;
    end
  end

  assign entry = mem[index];  // asynchronous read

endmodule

`default_nettype wire

/* rtl/victim_select.sv */
`timescale 1ns/1ns
`default_nettype none

module victim_select import cache_pkg::*; (
  input  logic       clock,
  input  logic       reset_n,
  input  logic       advance,
  input  tag_entry_t set_tags [NUM_WAYS],
  output way_t       victim
);

  logic [10:0] lfsr;
  way_t        rand_way;

  // x^11 + x^9 + 1, stepped twice per cycle
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      lfsr <= LFSR_SEED;
    end else if (advance) begin
      lfsr[8:0] <= lfsr[10:2];
      lfsr[9]   <= lfsr[0] ^ lfsr[2];
      lfsr[10]  <= lfsr[1] ^ lfsr[3];
    end
  end

  assign rand_way = way_t'(lfsr[1:0]);

  always_comb begin
    logic found;
    way_t w;

    found  = 1'b0;
    victim = rand_way;  // all dirty
    w      = rand_way;

    for (int i = 0; i < NUM_WAYS; i++) begin
      if (!found && !set_tags[i].valid) begin
        victim = way_t'(i);
        found  = 1'b1;
      end
    end

    // clean way, circular search after the random start
    for (int i = 1; i <= NUM_WAYS; i++) begin
      w = rand_way + way_t'(i);
      if (!found && !set_tags[w].dirty) begin
        victim = w;
        found  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_burst_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_burst_ctrl import cache_pkg::*; (
  input  logic  clock,
  input  logic  reset_n,
  input  logic  start_wb,
  input  logic  start_fill,
  input  addr_t line_addr,
  input  line_t wb_line,
  input  logic  mem_waitrequest,
  input  logic  mem_rd_valid,
  input  word_t mem_rd_data,
  output logic  done,
  output line_t fill_line,
  output addr_t mem_addr,
  output logic  mem_rd,
  output logic  mem_wr,
  output word_t mem_wr_data
);

  logic [WORD_SEL_WIDTH-1:0] beat;
  logic [WORD_SEL_WIDTH-1:0] next_beat;
  logic                      filling;
  logic                      wr_accept;
  logic                      rd_beat;
  logic                      last_beat;
  line_t                     wb_buf;

  assign next_beat = beat + 1'b1;
  assign wr_accept = mem_wr & ~mem_waitrequest;
  assign rd_beat   = filling & mem_rd_valid;
  assign last_beat = (beat == WORD_SEL_WIDTH'(LINE_WORDS - 1));

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mem_rd      <= 1'b0;
      mem_wr      <= 1'b0;
      mem_addr    <= '0;
      mem_wr_data <= '0;
      filling     <= 1'b0;
      beat        <= '0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start_wb) begin
        mem_addr    <= line_addr;
        mem_wr      <= 1'b1;
        mem_wr_data <= wb_line[0 +: WORD_WIDTH];  // word 0 first
        beat        <= '0;
      end else if (start_fill) begin
        mem_addr <= line_addr;
        mem_rd   <= 1'b1;
        filling  <= 1'b1;
        beat     <= '0;
      end else begin
        if (mem_rd && !mem_waitrequest) begin
          mem_rd <= 1'b0;  // request taken, beats follow
        end
        if (wr_accept) begin
          beat        <= next_beat;
          mem_wr_data <= wb_buf[next_beat*WORD_WIDTH +: WORD_WIDTH];
          if (last_beat) begin
            mem_wr <= 1'b0;
            done   <= 1'b1;
          end
        end
        if (rd_beat) begin
          beat <= next_beat;
          if (last_beat) begin
            filling <= 1'b0;
            done    <= 1'b1;
          end
        end
      end
    end
  end

  // victim copy for the rest of the write burst
  always_ff @(posedge clock) begin
    if (start_wb) begin
      wb_buf <= wb_line;
    end
  end

  // fill buffer, filled in beat order from the line base
  always_ff @(posedge clock) begin
    if (rd_beat) begin
      fill_line[beat*WORD_WIDTH +: WORD_WIDTH] <= mem_rd_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import cache_pkg::*; (
  input  logic                clock,
  input  logic                reset_n,
  input  addr_t               cpu_addr,
  input  logic                cpu_rd,
  input  logic                cpu_wr,
  input  be_t                 cpu_wr_be,
  input  word_t               cpu_wr_data,
  input  tag_entry_t          way_tags [NUM_WAYS],
  input  line_t               way_lines [NUM_WAYS],
  input  way_t                victim,
  input  logic                done,
  input  line_t               fill_line,
  output logic                cpu_rd_valid,
  output logic                cpu_waitrequest,
  output word_t               cpu_rd_data,
  output index_t              set_index,
  output logic [NUM_WAYS-1:0] tag_wr_en,
  output tag_entry_t          tag_wr_entry,
  output logic [NUM_WAYS-1:0] line_wr_en,
  output line_t               line_wr_data,
  output logic                advance,
  output logic                start_wb,
  output logic                start_fill,
  output addr_t               line_addr,
  output line_t               wb_line
);

  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    FILL
  } state_t;

  state_t                    state;
  state_t                    state_nxt;
  way_t                      fill_way;
  tag_t                      req_tag;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  addr_t                     req_base;
  logic                      req;
  logic                      hit;
  logic                      hit_ok;
  way_t                      hit_way;
  line_t                     hit_line;
  line_t                     merged_line;
  word_t                     be_mask;
  tag_entry_t                victim_tag;

  assign req_tag   = cpu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign set_index = cpu_addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign word_sel  = cpu_addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
  assign req_base  = {req_tag, set_index, {OFFSET_WIDTH{1'b0}}};
  assign req       = cpu_rd | cpu_wr;

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_tags[w].valid && way_tags[w].tag == req_tag) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  assign hit_line        = way_lines[hit_way];
  assign cpu_rd_data     = hit_line[word_sel*WORD_WIDTH +: WORD_WIDTH];
  assign hit_ok          = hit & (state == IDLE);
  assign cpu_waitrequest = req & ~hit_ok;
  assign cpu_rd_valid    = cpu_rd & hit_ok;

  // byte merge into the hit line
  always_comb begin
    for (int b = 0; b < BE_WIDTH; b++) begin
      be_mask[b*8 +: 8] = {8{cpu_wr_be[b]}};
    end
    merged_line = hit_line;
    merged_line[word_sel*WORD_WIDTH +: WORD_WIDTH] =
      (cpu_rd_data & ~be_mask) | (cpu_wr_data & be_mask);
  end

  assign victim_tag = way_tags[victim];
  assign wb_line    = way_lines[victim];

  always_comb begin
    state_nxt          = state;
    tag_wr_en          = '0;
    line_wr_en         = '0;
    tag_wr_entry.valid = 1'b1;
    tag_wr_entry.dirty = 1'b1;
    tag_wr_entry.tag   = req_tag;
    line_wr_data       = merged_line;
    advance            = 1'b0;
    start_wb           = 1'b0;
    start_fill         = 1'b0;
    line_addr          = req_base;

    case (state)
      IDLE: begin
        if (req && !hit_ok) begin
          advance = 1'b1;
          if (victim_tag.valid && victim_tag.dirty) begin
            start_wb  = 1'b1;
            line_addr = {victim_tag.tag, set_index, {OFFSET_WIDTH{1'b0}}};
            state_nxt = WRITEBACK;
          end else begin
            start_fill = 1'b1;
            state_nxt  = FILL;
          end
        end else if (cpu_wr && hit_ok) begin
          tag_wr_en[hit_way]  = 1'b1;  // line goes dirty
          line_wr_en[hit_way] = 1'b1;
        end
      end
      WRITEBACK: begin
        if (done) begin
          start_fill = 1'b1;
          state_nxt  = FILL;
        end
      end
      FILL: begin
        if (done) begin
          tag_wr_en[fill_way]  = 1'b1;
          line_wr_en[fill_way] = 1'b1;
          tag_wr_entry.dirty   = 1'b0;
          line_wr_data         = fill_line;
          state_nxt            = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state    <= IDLE;
      fill_way <= '0;
    end else begin
      state <= state_nxt;
      if (state == IDLE && req && !hit_ok) begin
        fill_way <= victim;  // held until the refill lands
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_top import cache_pkg::*; (
  input  logic  clock,
  input  logic  reset_n,
  input  addr_t cpu_addr,
  input  logic  cpu_rd,
  input  logic  cpu_wr,
  input  be_t   cpu_wr_be,
  input  word_t cpu_wr_data,
  output logic  cpu_rd_valid,
  output word_t cpu_rd_data,
  output logic  cpu_waitrequest,
  output addr_t mem_addr,
  output logic  mem_rd,
  output logic  mem_wr,
  output word_t mem_wr_data,
  input  logic  mem_waitrequest,
  input  logic  mem_rd_valid,
  input  word_t mem_rd_data
);

  tag_entry_t          way_tags [NUM_WAYS];
  line_t               way_lines [NUM_WAYS];
  index_t              set_index;
  logic [NUM_WAYS-1:0] tag_wr_en;
  tag_entry_t          tag_wr_entry;
  logic [NUM_WAYS-1:0] line_wr_en;
  line_t               line_wr_data;
  way_t                victim;
  logic                advance;
  logic                start_wb;
  logic                start_fill;
  addr_t               line_addr;
  line_t               wb_line;
  logic                done;
  line_t               fill_line;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_ram #(.entry_t(tag_entry_t)) tag_ram_i (
      .clock    (clock),
      .reset_n  (reset_n),
      .index    (set_index),
      .wr_en    (tag_wr_en[w]),
      .wr_entry (tag_wr_entry),
      .entry    (way_tags[w])
    );

    cache_ram #(.entry_t(line_t)) line_ram_i (
      .clock    (clock),
      .reset_n  (reset_n),
      .index    (set_index),
      .wr_en    (line_wr_en[w]),
      .wr_entry (line_wr_data),
      .entry    (way_lines[w])
    );
  end

  cache_ctrl ctrl_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_wr_be       (cpu_wr_be),
    .cpu_wr_data     (cpu_wr_data),
    .way_tags        (way_tags),
    .way_lines       (way_lines),
    .victim          (victim),
    .done            (done),
    .fill_line       (fill_line),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_waitrequest (cpu_waitrequest),
    .cpu_rd_data     (cpu_rd_data),
    .set_index       (set_index),
    .tag_wr_en       (tag_wr_en),
    .tag_wr_entry    (tag_wr_entry),
    .line_wr_en      (line_wr_en),
    .line_wr_data    (line_wr_data),
    .advance         (advance),
    .start_wb        (start_wb),
    .start_fill      (start_fill),
    .line_addr       (line_addr),
    .wb_line         (wb_line)
  );

  victim_select victim_i (
    .clock    (clock),
    .reset_n  (reset_n),
    .advance  (advance),
    .set_tags (way_tags),
    .victim   (victim)
  );

  mem_burst_ctrl burst_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .start_wb        (start_wb),
    .start_fill      (start_fill),
    .line_addr       (line_addr),
    .wb_line         (wb_line),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_valid    (mem_rd_valid),
    .mem_rd_data     (mem_rd_data),
    .done            (done),
    .fill_line       (fill_line),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data)
  );

endmodule

`default_nettype wire

/* testbench/mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model import cache_pkg::*; (
  input  logic  clock,
  input  logic  reset_n,
  input  addr_t mem_addr,
  input  logic  mem_rd,
  input  logic  mem_wr,
  input  word_t mem_wr_data,
  output logic  mem_waitrequest,
  output logic  mem_rd_valid,
  output word_t mem_rd_data
);

  word_t       words [addr_t];  // sparse, untouched words read as their address
  logic [31:0] lcg;
  addr_t       rd_base;
  int          rd_left;
  int          rd_beat;
  int          wr_beat;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t read_word(input addr_t a);
    if (words.exists(a)) begin
      return words[a];
    end
    return word_t'(a);
  endfunction

  always @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      lcg             <= 32'hb800_e70b;
      mem_waitrequest <= 1'b0;
      mem_rd_valid    <= 1'b0;
      mem_rd_data     <= '0;
      rd_base         <= '0;
      rd_left         <= 0;
      rd_beat         <= 0;
      wr_beat         <= 0;
    end else begin
      lcg             <= lcg_step(lcg);
      mem_waitrequest <= (lcg[31:30] == 2'b00);  // roughly one cycle in four
      mem_rd_valid    <= 1'b0;
      if (mem_rd && !mem_waitrequest) begin
        rd_base <= mem_addr;
        rd_left <= LINE_WORDS;
        rd_beat <= 0;
      end else if (rd_left > 0 && lcg[29:28] != 2'b00) begin
        mem_rd_valid <= 1'b1;
        mem_rd_data  <= read_word(rd_base + addr_t'(4 * rd_beat));
        rd_beat      <= rd_beat + 1;
        rd_left      <= rd_left - 1;
      end
      if (mem_wr && !mem_waitrequest) begin
        words[mem_addr + addr_t'(4 * wr_beat)] = mem_wr_data;
        wr_beat <= (wr_beat == LINE_WORDS - 1) ? 0 : wr_beat + 1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/cache_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_chk import cache_pkg::*; (
  input logic  clock,
  input logic  reset_n,
  input logic  mem_rd,
  input logic  mem_wr,
  input addr_t mem_addr,
  input word_t mem_wr_data,
  input logic  mem_waitrequest,
  input logic  cpu_rd,
  input logic  cpu_rd_valid
);

  a_rd_wr_excl: assert property (@(posedge clock) disable iff (!reset_n)
    !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr high in the same cycle");

  // read request held under back-pressure
  a_rd_hold: assert property (@(posedge clock) disable iff (!reset_n)
    mem_rd && mem_waitrequest |=> mem_rd && $stable(mem_addr))
    else $error("read request changed while mem_waitrequest was high");

  a_wr_hold: assert property (@(posedge clock) disable iff (!reset_n)
    mem_wr && mem_waitrequest |=> mem_wr && $stable(mem_addr) && $stable(mem_wr_data))
    else $error("write beat changed while mem_waitrequest was high");

  a_rd_valid: assert property (@(posedge clock) disable iff (!reset_n)
    cpu_rd_valid |-> cpu_rd)
    else $error("cpu_rd_valid high without cpu_rd");

endmodule

bind cache_top cache_chk chk_i (
  .clock           (clock),
  .reset_n         (reset_n),
  .mem_rd          (mem_rd),
  .mem_wr          (mem_wr),
  .mem_addr        (mem_addr),
  .mem_wr_data     (mem_wr_data),
  .mem_waitrequest (mem_waitrequest),
  .cpu_rd          (cpu_rd),
  .cpu_rd_valid    (cpu_rd_valid)
);

`default_nettype wire

/* testbench/tb_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache import cache_pkg::*; ();

  typedef struct packed {
    logic  wr;
    addr_t addr;
    be_t   be;
    word_t data;
    logic  hit;  // known hit with zero wait and a quiet memory bus
  } op_t;

  localparam int NUM_OPS = 26;

  // set 5 holds lines 0x050 0x454 0x858 0xc5c 0x1050 0x1454 0x1858
  op_t ops [NUM_OPS] = '{
    '{1'b0, 32'h0000_0100, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_0104, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b1, 32'h0000_0108, 4'h5, 32'haabb_ccdd, 1'b1},
    '{1'b0, 32'h0000_0108, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b1, 32'h0000_2204, 4'h9, 32'h1122_3344, 1'b0},
    '{1'b0, 32'h0000_2204, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b0, 32'h0000_2200, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b1, 32'h0000_0050, 4'hf, 32'ha0a0_0001, 1'b0},
    '{1'b1, 32'h0000_0454, 4'hf, 32'ha1a1_0002, 1'b0},
    '{1'b1, 32'h0000_0858, 4'h3, 32'ha2a2_0003, 1'b0},
    '{1'b1, 32'h0000_0c5c, 4'hc, 32'ha3a3_0004, 1'b0},
    '{1'b0, 32'h0000_0050, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b0, 32'h0000_0c5c, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b0, 32'h0000_0858, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b1, 32'h0000_1050, 4'hf, 32'ha4a4_0005, 1'b0},
    '{1'b1, 32'h0000_1454, 4'hf, 32'ha5a5_0006, 1'b0},
    '{1'b1, 32'h0000_1858, 4'h6, 32'ha6a6_0007, 1'b0},
    '{1'b0, 32'h0000_0050, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_0454, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_0858, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_0c5c, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_1050, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_1454, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_1858, 4'h0, 32'h0000_0000, 1'b0},
    '{1'b0, 32'h0000_0108, 4'h0, 32'h0000_0000, 1'b1},
    '{1'b0, 32'h0000_3000, 4'h0, 32'h0000_0000, 1'b0}
  };

  logic  clock = 1'b0;
  logic  reset_n;
  addr_t cpu_addr;
  logic  cpu_rd;
  logic  cpu_wr;
  be_t   cpu_wr_be;
  word_t cpu_wr_data;
  logic  cpu_rd_valid;
  word_t cpu_rd_data;
  logic  cpu_waitrequest;
  addr_t mem_addr;
  logic  mem_rd;
  logic  mem_wr;
  word_t mem_wr_data;
  logic  mem_waitrequest;
  logic  mem_rd_valid;
  word_t mem_rd_data;

  word_t shadow [addr_t];
  int    word_errors;
  int    addr_errors;
  int    flag_errors;
  int    other_errors;
  int    wb_bursts;
  int    wb_beat;

  cache_top dut_i (.*);

  mem_model mem_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_valid    (mem_rd_valid),
    .mem_rd_data     (mem_rd_data)
  );

  always #5 clock = ~clock;

  function automatic word_t shadow_read(input addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return word_t'(a);  // untouched memory holds its own address
  endfunction

  function automatic addr_t line_base(input addr_t a);
    return {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  endfunction

  // set index and byte offset bits only
  function automatic addr_t set_and_offset(input addr_t a);
    return a & addr_t'((1 << (INDEX_WIDTH + OFFSET_WIDTH)) - 1);
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      addr_errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // memory bus monitor sampled on the edge that accepts a request or beat
  always @(posedge clock) begin
    if (reset_n) begin
      if (mem_rd && !mem_waitrequest) begin
        check_addr("mem_addr (fill)", mem_addr, line_base(cpu_addr));
      end
      if (mem_wr && !mem_waitrequest) begin
        if (wb_beat == 0) begin
          wb_bursts++;
        end
        // victim lives in the request's set
        check_addr("mem_addr set and offset (write-back)", set_and_offset(mem_addr),
                   set_and_offset(line_base(cpu_addr)));
        check_word("mem_wr_data", mem_wr_data, shadow_read(mem_addr + addr_t'(4 * wb_beat)));
        wb_beat = (wb_beat + 1) % LINE_WORDS;
      end
    end
  end

  task automatic run_op(input op_t op);
    logic waiting;
    @(posedge clock);
    cpu_addr    <= op.addr;
    cpu_rd      <= ~op.wr;
    cpu_wr      <= op.wr;
    cpu_wr_be   <= op.wr ? op.be : '0;
    cpu_wr_data <= op.data;
    waiting = 1'b1;
    while (waiting) begin
      @(negedge clock);
      if (op.hit) begin
        check_flag("cpu_waitrequest", cpu_waitrequest, 1'b0);
        check_flag("mem_rd", mem_rd, 1'b0);
        check_flag("mem_wr", mem_wr, 1'b0);
      end
      waiting = cpu_waitrequest;
    end
    if (op.wr) begin
      shadow[op.addr] = merge_bytes(shadow_read(op.addr), op.data, op.be);
    end else begin
      check_flag("cpu_rd_valid", cpu_rd_valid, 1'b1);
      check_word("cpu_rd_data", cpu_rd_data, shadow_read(op.addr));
    end
  endtask

  initial begin
    word_errors  = 0;
    addr_errors  = 0;
    flag_errors  = 0;
    other_errors = 0;
    wb_bursts    = 0;
    wb_beat      = 0;
    reset_n      = 1'b0;
    cpu_addr     = '0;
    cpu_rd       = 1'b0;
    cpu_wr       = 1'b0;
    cpu_wr_be    = '0;
    cpu_wr_data  = '0;
    repeat (3) @(posedge clock);
    reset_n <= 1'b1;
    for (int i = 0; i < NUM_OPS; i++) begin
      run_op(ops[i]);
    end
    @(posedge clock);
    cpu_rd <= 1'b0;
    cpu_wr <= 1'b0;
    repeat (4) @(posedge clock);
    if (wb_bursts == 0) begin
      other_errors++;
      $display("no dirty line was written back to memory");
    end
    $display("errors: %0d data, %0d address, %0d flag, %0d other",
             word_errors, addr_errors, flag_errors, other_errors);
    if (word_errors + addr_errors + flag_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog with a generous bound per table entry
  initial begin
    repeat (NUM_OPS * 200) @(posedge clock);
    $display("watchdog expired after %0d cycles, a request never completed", NUM_OPS * 200);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/cache_pkg.sv
rtl/cache_ram.sv
rtl/victim_select.sv
rtl/mem_burst_ctrl.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/mem_model.sv
testbench/cache_chk.sv
testbench/tb_cache.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_cache -f filelist.f -o tb_cache_sim
./obj_dir/tb_cache_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
